// File: network_perf_top.f
+incdir+.
net_pkg.sv
phy_reset_sequencer.sv
mac_perf_counters.sv
port_perf_readout.sv
perf_readout_merge.sv
network_perf_top.sv
network_perf_properties.sv
tb_clock_gen.sv
network_perf_tb.sv

// File: network_perf_tb.sv
`timescale 1ns/1ps
`include "net_settings.svh"

module network_perf_tb;

	localparam int NUM_PORTS = `NET_NUM_PORTS;
	// Frame rounds per direction, up to 8 beats each
	localparam int ROUNDS = 12;
	localparam int STIM_CYCLES = 2 * ROUNDS * 8 + 6 * (5 * NUM_PORTS + 4) + 16;
	localparam longint WATCHDOG_NS = 8 * (16 + `NET_PHY_RESET_CYCLES + STIM_CYCLES + 500);

	logic clk_125mhz;
	logic rst_n;
	net_pkg::eth_rx_bus_t [NUM_PORTS-1:0] rx_bus;
	net_pkg::eth_tx_bus_t [NUM_PORTS-1:0] tx_bus;
	logic perf_rd;
	net_pkg::perf_req_t perf_req;
	logic [NUM_PORTS-1:0] perf_rst;
	logic phy_rst_n;
	logic perf_valid;
	logic [`NET_CNT_WIDTH-1:0] perf_value;

	// Model counters, indexed by register id
	logic [`NET_CNT_WIDTH-1:0] model_cnt [NUM_PORTS][5];
	// Outstanding reads, oldest first
	logic [`NET_CNT_WIDTH-1:0] exp_q [$];
	string name_q [$];
	logic [`NET_CNT_WIDTH-1:0] chk_exp;
	string chk_name;
	int unsigned lcg_state = 227;
	int phy_cycles;

	tb_clock_gen #(.RESET_CYCLES(16)) u_clk (.clk_125mhz(clk_125mhz), .rst_n(rst_n));

	network_perf_top u_dut (.*);

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped on first error");
	endtask

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 8;
	endfunction

	// Expected read value, unmapped ids give zero
	function automatic logic [`NET_CNT_WIDTH-1:0] expected_value(input int port, input int regid);
		if (regid > 4) begin
			return '0;
		end
		return model_cnt[port][regid];
	endfunction

	// Advance to 1 ns past the edge, strobes and buses back to idle
	task automatic next_cycle();
		@(posedge clk_125mhz);
		#1;
		perf_rd  = 1'b0;
		perf_req = '0;
		perf_rst = '0;
		rx_bus   = '0;
		tx_bus   = '0;
	endtask

	task automatic drive_beat(input bit is_tx, input int p, input bit start,
			input logic [2:0] nb, input bit commit, input bit drop);
		logic [31:0] word;
		word = lcg_next();
		if (is_tx) begin
			tx_bus[p] = '{start: start, data_valid: 1'b1, bytes_valid: nb, data: word};
		end else begin
			rx_bus[p] = '{start: start, data_valid: 1'b1, bytes_valid: nb, data: word,
				commit: commit, drop: drop};
		end
		// A clear in the same cycle swallows the event
		if (!perf_rst[p] && is_tx) begin
			model_cnt[p][net_pkg::REG_TX_FRAMES] += start;
			model_cnt[p][net_pkg::REG_TX_BYTES]  += nb;
		end else if (!perf_rst[p]) begin
			model_cnt[p][net_pkg::REG_RX_FRAMES] += commit;
			model_cnt[p][net_pkg::REG_RX_DROPS]  += drop;
			model_cnt[p][net_pkg::REG_RX_BYTES]  += nb;
		end
	endtask

	// All ports send one frame per round, random length and status
	task automatic send_frames(input bit is_tx, input int rounds);
		int len [NUM_PORTS];
		bit good [NUM_PORTS];
		bit last;
		logic [2:0] nb;
		for (int r = 0; r < rounds; r++) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				len[p]  = 1 + lcg_next() % 8;
				good[p] = (lcg_next() % 3) != 0;
			end
			for (int c = 0; c < 8; c++) begin
				next_cycle();
				for (int p = 0; p < NUM_PORTS; p++) begin
					last = (c == len[p] - 1);
					// Only the last beat may be partial
					nb = last ? 3'(1 + lcg_next() % 4) : 3'd4;
					if (c < len[p]) begin
						drive_beat(is_tx, p, c == 0, nb, last && good[p], last && !good[p]);
					end
				end
			end
		end
	endtask

	task automatic issue_read(input int p, input int regid, input string name);
		next_cycle();
		perf_rd        = 1'b1;
		perf_req.port  = `NET_PORT_BITS'(p);
		perf_req.regid = net_pkg::perf_regid_t'(regid);
		exp_q.push_back(expected_value(p, regid));
		name_q.push_back(name);
	endtask

	// Back-to-back sweep of every port and register, then drain
	task automatic read_all(input string name);
		for (int p = 0; p < NUM_PORTS; p++) begin
			for (int r = 0; r < 5; r++) begin
				issue_read(p, r, name);
			end
		end
		while (exp_q.size() != 0) begin
			next_cycle();
		end
	endtask

	////////////////////
	// Compare

	// Sampled mid-cycle, away from the edge
	always @(negedge clk_125mhz) begin
		assert (u_dut.u_props.assert_errors == 0)
		else report_fail("A concurrent property check failed during the run");
		if (rst_n && perf_valid) begin
			assert (exp_q.size() != 0)
			else report_fail("perf_valid went high with no read outstanding");
			chk_exp  = exp_q.pop_front();
			chk_name = name_q.pop_front();
			assert (perf_value === chk_exp)
			else report_fail($sformatf("FAIL %s expected 0x%0h actual 0x%0h",
				chk_name, chk_exp, perf_value));
		end
	end

	initial begin
		#(WATCHDOG_NS);
		report_fail("Watchdog timeout, the run did not complete in time");
	end

	////////////////////
	// Stimulus

	initial begin
		perf_rd  = 1'b0;
		perf_req = '0;
		perf_rst = '0;
		rx_bus   = '0;
		tx_bus   = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			for (int r = 0; r < 5; r++) begin
				model_cnt[p][r] = '0;
			end
		end
		repeat (4) @(posedge clk_125mhz);
		#1;
		assert (!phy_rst_n && !perf_valid)
		else report_fail("phy_rst_n or perf_valid high during reset");

		// PHY release, counted from the first edge with rst_n high
		wait (rst_n);
		@(posedge clk_125mhz);
		#1;
		assert (!phy_rst_n) else report_fail("phy_rst_n high right after reset");
		phy_cycles = 0;
		while (!phy_rst_n && phy_cycles <= `NET_PHY_RESET_CYCLES + 8) begin
			@(posedge clk_125mhz);
			#1;
			phy_cycles++;
		end
		assert (phy_cycles == `NET_PHY_RESET_CYCLES)
		else report_fail($sformatf("FAIL phy_reset expected %0d actual %0d",
			`NET_PHY_RESET_CYCLES, phy_cycles));

		read_all("after_reset");
		send_frames(1'b0, ROUNDS);
		read_all("rx_counts");
		send_frames(1'b1, ROUNDS);
		read_all("tx_counts");

		// Clear port 2 while every port sees a committed beat
		next_cycle();
		perf_rst[2] = 1'b1;
		for (int r = 0; r < 5; r++) begin
			model_cnt[2][r] = '0;
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			drive_beat(1'b0, p, 1'b1, 3'd4, 1'b1, 1'b0);
		end
		read_all("clear_one_port");

		issue_read(1, 5, "unmapped_regid");
		issue_read(3, 16'hffff, "unmapped_regid");
		while (exp_q.size() != 0) begin
			next_cycle();
		end

		if (u_dut.u_props.assert_errors == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			report_fail("A concurrent property check failed during the run");
		end
	end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk_125mhz,
	output logic rst_n
);

	// 8 ns period
	initial begin
		clk_125mhz = 1'b0;
		forever #4 clk_125mhz = ~clk_125mhz;
	end

	// Release just after an edge, clear of the sampling point
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_125mhz);
		#1;
		rst_n = 1'b1;
	end

endmodule

// File: network_perf_properties.sv
`timescale 1ns/1ps

module network_perf_properties (
	input logic clk_125mhz,
	input logic rst_n,
	input logic perf_rd,
	input logic phy_rst_n,
	input logic perf_valid
);

	// Failure count, polled by the testbench
	int assert_errors = 0;

	// Two register stages between strobe and result
	a_rd_latency: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
		perf_valid == $past(perf_rd, 2))
	else begin
		assert_errors++;
		$error("perf_valid does not follow perf_rd by exactly two cycles");
	end

	// PHY reset is released once per system reset
	a_phy_hold: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
		!$fell(phy_rst_n))
	else begin
		assert_errors++;
		$error("phy_rst_n fell while rst_n was high");
	end

	a_valid_in_reset: assert property (@(posedge clk_125mhz) !rst_n |-> !perf_valid)
	else begin
		assert_errors++;
		$error("perf_valid high during reset");
	end

endmodule

bind network_perf_top network_perf_properties u_props (.*);

// File: network_perf_top.sv
`timescale 1ns/1ps
`include "net_settings.svh"

module network_perf_top (
	input  logic                                      clk_125mhz,
	input  logic                                      rst_n,
	input  net_pkg::eth_rx_bus_t [`NET_NUM_PORTS-1:0] rx_bus,
	input  net_pkg::eth_tx_bus_t [`NET_NUM_PORTS-1:0] tx_bus,
	input  logic                                      perf_rd,
	input  net_pkg::perf_req_t                        perf_req,
	input  logic [`NET_NUM_PORTS-1:0]                 perf_rst,
	output logic                                      phy_rst_n,
	output logic                                      perf_valid,
	output logic [`NET_CNT_WIDTH-1:0]                 perf_value
);

	// Counter banks, one per port
	net_pkg::mac_perf_data_t [`NET_NUM_PORTS-1:0] port_counters;
	// Per-port readout results into the merge
	net_pkg::perf_rsp_t      [`NET_NUM_PORTS-1:0] port_rsp;

	////////////////////
	// PHY reset

	phy_reset_sequencer u_phy_reset (
		.clk_125mhz (clk_125mhz),
		.rst_n      (rst_n),
		.phy_rst_n  (phy_rst_n)
	);

	////////////////////
	// Per-port counters

	// Request and strobe are broadcast, each readout decodes its own port
	for (genvar p = 0; p < `NET_NUM_PORTS; p++) begin : g_port
		mac_perf_counters u_counters (
			.clk_125mhz (clk_125mhz),
			.rst_n      (rst_n),
			.rx_bus     (rx_bus[p]),
			.tx_bus     (tx_bus[p]),
			.perf_rst   (perf_rst[p]),
			.counters   (port_counters[p])
		);

		port_perf_readout #(
			.PORT_INDEX (p)
		) u_readout (
			.clk_125mhz (clk_125mhz),
			.rst_n      (rst_n),
			.perf_rd    (perf_rd),
			.perf_req   (perf_req),
			.counters   (port_counters[p]),
			.rsp        (port_rsp[p])
		);
	end

	////////////////////
	// Shared result bus

	perf_readout_merge u_merge (
		.clk_125mhz (clk_125mhz),
		.rst_n      (rst_n),
		.rsp        (port_rsp),
		.perf_valid (perf_valid),
		.perf_value (perf_value)
	);

endmodule

// File: perf_readout_merge.sv
`timescale 1ns/1ps
`include "net_settings.svh"

module perf_readout_merge (
	input  logic                                     clk_125mhz,
	input  logic                                     rst_n,
	input  net_pkg::perf_rsp_t [`NET_NUM_PORTS-1:0]  rsp,
	output logic                                     perf_valid,
	output logic [`NET_CNT_WIDTH-1:0]                perf_value
);

	// Winner of this cycle's scan
	logic                      win_valid;
	logic [`NET_CNT_WIDTH-1:0] win_value;

	////////////////////
	// Priority scan

	// Only one port matches a request, so normally one valid
	// Scan high to low, lowest valid index ends up last and wins
	always_comb begin
		win_valid = 1'b0;
		win_value = '0;
		for (int i = `NET_NUM_PORTS - 1; i >= 0; i--) begin
			if (rsp[i].valid) begin
				win_valid = 1'b1;
				win_value = rsp[i].value;
			end
		end
	end

	////////////////////
	// Output register

	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			perf_valid <= 1'b0;
		end else begin
			perf_valid <= win_valid;
		end
	end

	// Last result stays on the bus between reads
	always_ff @(posedge clk_125mhz) begin
		if (win_valid) begin
			perf_value <= win_value;
		end
	end

endmodule

// File: port_perf_readout.sv
`timescale 1ns/1ps
`include "net_settings.svh"

module port_perf_readout #(
	parameter int PORT_INDEX = 0
) (
	input  logic                    clk_125mhz,
	input  logic                    rst_n,
	input  logic                    perf_rd,
	input  net_pkg::perf_req_t      perf_req,
	input  net_pkg::mac_perf_data_t counters,
	output net_pkg::perf_rsp_t      rsp
);

	// This port is addressed by the strobe
	logic                      hit;
	// Counter picked by regid
	logic [`NET_CNT_WIDTH-1:0] sel_value;
	// Registered response
	logic                      rsp_valid;
	logic [`NET_CNT_WIDTH-1:0] rsp_value;

	////////////////////
	// Address decode

	assign hit = perf_rd && (perf_req.port == `NET_PORT_BITS'(PORT_INDEX));

	// Unmapped register ids read back as zero
	always_comb begin
		case (perf_req.regid)
			net_pkg::REG_RX_FRAMES: sel_value = counters.rx_frames;
			net_pkg::REG_RX_DROPS:  sel_value = counters.rx_drops;
			net_pkg::REG_RX_BYTES:  sel_value = counters.rx_bytes;
			net_pkg::REG_TX_FRAMES: sel_value = counters.tx_frames;
			net_pkg::REG_TX_BYTES:  sel_value = counters.tx_bytes;
			default:                sel_value = '0;
		endcase
	end

	////////////////////
	// Response register

	// One cycle strobe per accepted read
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= hit;
		end
	end

	// Snapshot of the counter as seen in the strobe cycle
	always_ff @(posedge clk_125mhz) begin
		if (hit) begin
			rsp_value <= sel_value;
		end
	end

	assign rsp.valid = rsp_valid;
	assign rsp.value = rsp_value;

endmodule

// File: mac_perf_counters.sv
`timescale 1ns/1ps
`include "net_settings.svh"

module mac_perf_counters (
	input  logic                    clk_125mhz,
	input  logic                    rst_n,
	input  net_pkg::eth_rx_bus_t    rx_bus,
	input  net_pkg::eth_tx_bus_t    tx_bus,
	input  logic                    perf_rst,
	output net_pkg::mac_perf_data_t counters
);

	// Byte increments widened to counter width
	logic [`NET_CNT_WIDTH-1:0] rx_byte_inc;
	logic [`NET_CNT_WIDTH-1:0] tx_byte_inc;

	// Zero when the cycle carries no data
	assign rx_byte_inc = rx_bus.data_valid ? `NET_CNT_WIDTH'(rx_bus.bytes_valid) : '0;
	assign tx_byte_inc = tx_bus.data_valid ? `NET_CNT_WIDTH'(tx_bus.bytes_valid) : '0;

	////////////////////
	// Receive counters

	// Commit and drop both mark end of frame
	// Byte count covers good and bad frames alike
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			counters.rx_frames <= '0;
			counters.rx_drops  <= '0;
			counters.rx_bytes  <= '0;
		end else if (perf_rst) begin
			// Software clear beats any event this cycle
			counters.rx_frames <= '0;
			counters.rx_drops  <= '0;
			counters.rx_bytes  <= '0;
		end else begin
			if (rx_bus.commit) begin
				counters.rx_frames <= counters.rx_frames + 1'b1;
			end
			if (rx_bus.drop) begin
				counters.rx_drops <= counters.rx_drops + 1'b1;
			end
			// Wraps at NET_CNT_WIDTH
			counters.rx_bytes <= counters.rx_bytes + rx_byte_inc;
		end
	end

	////////////////////
	// Transmit counters

	// Frames counted at start, no end status on this bus
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			counters.tx_frames <= '0;
			counters.tx_bytes  <= '0;
		end else if (perf_rst) begin
			counters.tx_frames <= '0;
			counters.tx_bytes  <= '0;
		end else begin
			if (tx_bus.start) begin
				counters.tx_frames <= counters.tx_frames + 1'b1;
			end
			counters.tx_bytes <= counters.tx_bytes + tx_byte_inc;
		end
	end

endmodule

// File: phy_reset_sequencer.sv
`timescale 1ns/1ps
`include "net_settings.svh"

module phy_reset_sequencer (
	input  logic clk_125mhz,
	input  logic rst_n,
	output logic phy_rst_n
);

	// One extra code so the terminal count fits
	localparam int CNT_BITS = $clog2(`NET_PHY_RESET_CYCLES + 1);

	// Cycles elapsed since rst_n went high
	logic [CNT_BITS-1:0] hold_count;

	////////////////////
	// Hold counter

	// Strap pins share the PHY data lines
	// Coupling caps need time to discharge before the PHY samples them
	always_ff @(posedge clk_125mhz or negedge rst_n) begin
		if (!rst_n) begin
			hold_count <= '0;
			phy_rst_n  <= 1'b0;
		end else if (!phy_rst_n) begin
			// Release on the terminal count, counter freezes afterwards
			if (hold_count == CNT_BITS'(`NET_PHY_RESET_CYCLES)) begin
				phy_rst_n <= 1'b1;
			end else begin
				hold_count <= hold_count + 1'b1;
			end
		end
	end

endmodule

// File: net_pkg.sv
`include "net_settings.svh"

package net_pkg;

	////////////////////
	// MAC buses

	// Receive side, one word per clk_125mhz cycle
	typedef struct packed {
		logic        start;
		logic        data_valid;
		logic [2:0]  bytes_valid;
		logic [31:0] data;
		logic        commit;
		logic        drop;
	} eth_rx_bus_t;

	// Transmit side, no end-of-frame status
	typedef struct packed {
		logic        start;
		logic        data_valid;
		logic [2:0]  bytes_valid;
		logic [31:0] data;
	} eth_tx_bus_t;

	////////////////////
	// Counters and readout

	// All five counters of one port
	typedef struct packed {
		logic [`NET_CNT_WIDTH-1:0] rx_frames;
		logic [`NET_CNT_WIDTH-1:0] rx_drops;
		logic [`NET_CNT_WIDTH-1:0] rx_bytes;
		logic [`NET_CNT_WIDTH-1:0] tx_frames;
		logic [`NET_CNT_WIDTH-1:0] tx_bytes;
	} mac_perf_data_t;

	// Register map of a port's counter bank
	typedef enum logic [`NET_REGID_BITS-1:0] {
		REG_RX_FRAMES = 0,
		REG_RX_DROPS  = 1,
		REG_RX_BYTES  = 2,
		REG_TX_FRAMES = 3,
		REG_TX_BYTES  = 4
	} perf_regid_t;

	// Software read request
	typedef struct packed {
		logic [`NET_PORT_BITS-1:0] port;
		perf_regid_t               regid;
	} perf_req_t;

	// Per-port result, also the merge input
	typedef struct packed {
		logic                      valid;
		logic [`NET_CNT_WIDTH-1:0] value;
	} perf_rsp_t;

endpackage

// File: net_settings.svh
`ifndef NET_SETTINGS_SVH
`define NET_SETTINGS_SVH

////////////////////
// Port geometry

// Number of MAC ports with counter banks
`define NET_NUM_PORTS 4

// Port index width, must cover NET_NUM_PORTS
`define NET_PORT_BITS 2

////////////////////
// Counter readout

// Width of every performance counter
`define NET_CNT_WIDTH 48

// Register id width on the readout request
`define NET_REGID_BITS 16

////////////////////
// PHY bring-up

// Cycles of clk_125mhz the PHY reset stays low after rst_n
// Raise for hardware so the strap pins settle
`define NET_PHY_RESET_CYCLES 4096

`endif
